//--- flist.f
+incdir+test
design/bram_pkg.sv
design/board_pkg.sv
design/boot_ram_array.sv
design/boot_ram_port.sv
design/board_config.sv
design/eth_phy_regs.sv
design/soc_board_top.sv
test/tb_soc_board_top.sv

//--- run.sh
#!/usr/bin/env bash
# compile the board glue testbench with Verilator, run it, and grade the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_soc_board_top -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

//--- test/tb_stimulus.svh
// stimulus table for the board glue testbench, one record per test applied in order
`ifndef TB_STIMULUS_SVH
`define TB_STIMULUS_SVH

typedef enum logic [2:0] {
   OP_RESET, OP_WRITE, OP_READ, OP_STALL, OP_DIP, OP_PHY
} op_kind_t;

// drive is the DIP pattern in [3:0], or {txd, en, er, mdio_o, mdio_t} for the PHY
// pins is {emdio_i, mac_rstn, clk_locked}; exp is the reset vector or o_erstn
typedef struct packed {
   logic [79:0]          name;    // ten characters
   op_kind_t             op;
   bram_pkg::byte_addr_t addr;
   bram_pkg::strb_t      strb;
   logic [7:0]           drive;
   logic [2:0]           pins;
   logic [31:0]          exp;
} stim_t;

localparam int STIM_LEN = 30;

localparam stim_t STIM [STIM_LEN] = '{
   // name          op        addr     strb   drive  pins    exp
   '{"rst_values", OP_RESET, 12'h000, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"wr_l000_w0", OP_WRITE, 12'h000, 8'hff, 8'h00, 3'b000, 32'h0},
   '{"wr_l000_w1", OP_WRITE, 12'h008, 8'hff, 8'h00, 3'b000, 32'h0},
   '{"wr_l001_w0", OP_WRITE, 12'h010, 8'hff, 8'h00, 3'b000, 32'h0},
   '{"wr_l001_w1", OP_WRITE, 12'h018, 8'hff, 8'h00, 3'b000, 32'h0},
   '{"wr_l127_w1", OP_WRITE, 12'h7f8, 8'hff, 8'h00, 3'b000, 32'h0},
   '{"wr_l255_w0", OP_WRITE, 12'hff0, 8'hff, 8'h00, 3'b000, 32'h0},
   '{"rd_l000_w0", OP_READ,  12'h000, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"rd_l000_w1", OP_READ,  12'h008, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"rd_l001_w0", OP_READ,  12'h010, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"rd_l001_w1", OP_READ,  12'h018, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"rd_l127_w1", OP_READ,  12'h7f8, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"rd_l255_w0", OP_READ,  12'hff0, 8'h00, 8'h00, 3'b000, 32'h0},
   // partial strobes, the other lane must not move
   '{"wr_merge_0", OP_WRITE, 12'h010, 8'ha5, 8'h00, 3'b000, 32'h0},
   '{"rd_merge_0", OP_READ,  12'h010, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"rd_merge_1", OP_READ,  12'h018, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"wr_merge_2", OP_WRITE, 12'h7f8, 8'h80, 8'h00, 3'b000, 32'h0},
   '{"rd_merge_2", OP_READ,  12'h7f8, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"rd_stall_0", OP_STALL, 12'h000, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"rd_stall_1", OP_STALL, 12'hff0, 8'h00, 8'h00, 3'b000, 32'h0},
   '{"dip_p_0001", OP_DIP,   12'h000, 8'h00, 8'h01, 3'b000, board_pkg::RESET_VEC_DRAM},
   '{"dip_p_0011", OP_DIP,   12'h000, 8'h00, 8'h03, 3'b000, board_pkg::RESET_VEC_KERNEL},
   '{"dip_p_1110", OP_DIP,   12'h000, 8'h00, 8'h0e, 3'b000, board_pkg::RESET_VEC_ROM},
   '{"dip_p_0101", OP_DIP,   12'h000, 8'h00, 8'h05, 3'b000, board_pkg::RESET_VEC_DRAM},
   '{"dip_p_0010", OP_DIP,   12'h000, 8'h00, 8'h02, 3'b000, board_pkg::RESET_VEC_ROM},
   '{"phy_step_0", OP_PHY,   12'h000, 8'h00, 8'h5a, 3'b111, 32'h1},
   '{"phy_step_1", OP_PHY,   12'h000, 8'h00, 8'ha5, 3'b010, 32'h0},
   '{"phy_step_2", OP_PHY,   12'h000, 8'h00, 8'hff, 3'b101, 32'h0},
   '{"phy_step_3", OP_PHY,   12'h000, 8'h00, 8'h31, 3'b111, 32'h1},
   '{"phy_step_4", OP_PHY,   12'h000, 8'h00, 8'h01, 3'b000, 32'h0}
};

`endif

//--- test/tb_soc_board_top.sv
// testbench for the board glue top; walks the stimulus table over boot RAM, DIP decode and PHY stage
module tb_soc_board_top;

   `include "tb_stimulus.svh"

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 4;
   localparam int RUN_CYCLES   = STIM_LEN * 20 + RESET_CYCLES;

   logic                   i_etx_clk = 1'b0;
   logic                   i_rst;
   logic                   i_req_valid;
   logic                   o_req_ready;
   logic                   i_req_we;
   bram_pkg::byte_addr_t   i_req_addr;
   bram_pkg::strb_t        i_req_strb;
   bram_pkg::word_t        i_req_wdata;
   logic                   o_rsp_valid;
   logic                   i_rsp_ready;
   bram_pkg::word_t        o_rsp_rdata;
   board_pkg::dip_t        i_dip;
   board_pkg::reset_vec_t  o_reset_vector;
   board_pkg::mii_nibble_t i_tx_data;
   logic                   i_tx_en;
   logic                   i_tx_er;
   logic                   i_mdio_o;
   logic                   i_mdio_t;
   logic                   o_mdio_i;
   logic                   i_mac_rstn;
   logic                   i_clk_locked;
   board_pkg::phy_txd_t    o_etxd;
   logic                   o_etx_en;
   logic                   o_etx_er;
   logic                   o_emdio_o;
   logic                   o_emdio_t;
   logic                   i_emdio_i;
   logic                   o_erstn;

   bram_pkg::word_t        model [int];   // expected memory, keyed by word address
   board_pkg::reset_vec_t  last_vec;
   logic [12:0]            last_phy;      // registered PHY pins of the previous step
   int                     errors = 0;
   int                     tests_done = 0;

   always #(CLK_PERIOD / 2) i_etx_clk = ~i_etx_clk;

   soc_board_top soc_board_top_inst (.*);

   ////////////////////////////////////////////////////////////////////////////
   // helpers

   task automatic report_mismatch(input logic [79:0] name, input logic [63:0] exp,
                                  input logic [63:0] act);
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
   endtask

   function automatic int word_key(input bram_pkg::byte_addr_t addr);
      return int'(addr >> bram_pkg::OFFSET_BITS);
   endfunction

   // byte-wise merge into the model, same as the strobe rule
   function automatic void store_word(input bram_pkg::byte_addr_t addr,
                                      input bram_pkg::strb_t strb,
                                      input bram_pkg::word_t data);
      bram_pkg::word_t word;
      word = model.exists(word_key(addr)) ? model[word_key(addr)] : '0;
      for (int b = 0; b < bram_pkg::WORD_WIDTH / 8; b++) begin
         if (strb[b]) word[b*8 +: 8] = data[b*8 +: 8];
      end
      model[word_key(addr)] = word;
   endfunction

   // holds valid until ready, returns on the transfer edge
   task automatic issue_request(input stim_t t, input logic we, input bram_pkg::word_t wdata);
      int waited;
      waited = 0;
      @(posedge i_etx_clk);
      i_req_valid <= 1'b1;
      i_req_we    <= we;
      i_req_addr  <= t.addr;
      i_req_strb  <= t.strb;
      i_req_wdata <= wdata;
      @(negedge i_etx_clk);
      while (!o_req_ready && waited < 16) begin
         waited++;
         @(negedge i_etx_clk);
      end
      if (!o_req_ready) begin
         errors++;
         $display("%s: request was not accepted within 16 cycles", t.name);
      end
      @(posedge i_etx_clk);
      i_req_valid <= 1'b0;
      i_req_we    <= 1'b0;
   endtask

   task automatic run_read(input stim_t t);
      bram_pkg::word_t exp;
      exp = model[word_key(t.addr)];
      if (t.op == OP_STALL) begin
         @(posedge i_etx_clk);
         i_rsp_ready <= 1'b0;
      end
      issue_request(t, 1'b0, '0);
      @(negedge i_etx_clk);   // one cycle after accept
      if (o_rsp_valid !== 1'b1) report_mismatch(t.name, 64'd1, 64'(o_rsp_valid));
      if (o_rsp_rdata !== exp) report_mismatch(t.name, exp, o_rsp_rdata);
      if (t.op == OP_STALL) begin
         repeat (3) begin
            @(negedge i_etx_clk);
            if ({o_rsp_valid, o_req_ready} !== 2'b10)
               report_mismatch(t.name, 64'h2, 64'({o_rsp_valid, o_req_ready}));
            if (o_rsp_rdata !== exp) report_mismatch(t.name, exp, o_rsp_rdata);
         end
         @(posedge i_etx_clk);
         i_rsp_ready <= 1'b1;
         @(negedge i_etx_clk);
         if (o_rsp_rdata !== exp) report_mismatch(t.name, exp, o_rsp_rdata);
      end
      @(posedge i_etx_clk);   // response transfers here
      @(negedge i_etx_clk);
      if (o_rsp_valid !== 1'b0) begin
         errors++;
         $display("%s: response still valid after it was taken", t.name);
      end
   endtask

   task automatic run_dip(input stim_t t);
      @(posedge i_etx_clk);
      i_dip <= t.drive[3:0];
      repeat (3) @(negedge i_etx_clk);
      if (o_reset_vector !== last_vec) report_mismatch(t.name, 64'(last_vec), 64'(o_reset_vector));
      @(negedge i_etx_clk);   // third edge after the change
      if (o_reset_vector !== t.exp) report_mismatch(t.name, 64'(t.exp), 64'(o_reset_vector));
      last_vec = t.exp;
   endtask

   task automatic run_phy(input stim_t t);
      logic [12:0] exp_regs;
      logic [12:0] act_regs;
      exp_regs = {4'h0, t.drive, t.pins[2]};
      @(posedge i_etx_clk);
      {i_tx_data, i_tx_en, i_tx_er, i_mdio_o, i_mdio_t} <= t.drive;
      {i_emdio_i, i_mac_rstn, i_clk_locked} <= t.pins;
      @(negedge i_etx_clk);
      if (o_erstn !== t.exp[0]) report_mismatch(t.name, 64'(t.exp[0]), 64'(o_erstn));
      // registered pins still show the previous step
      act_regs = {o_etxd, o_etx_en, o_etx_er, o_emdio_o, o_emdio_t, o_mdio_i};
      if (act_regs !== last_phy) report_mismatch(t.name, 64'(last_phy), 64'(act_regs));
      @(negedge i_etx_clk);
      act_regs = {o_etxd, o_etx_en, o_etx_er, o_emdio_o, o_emdio_t, o_mdio_i};
      if (act_regs !== exp_regs) report_mismatch(t.name, 64'(exp_regs), 64'(act_regs));
      last_phy = exp_regs;
   endtask

   task automatic check_reset_values(input stim_t t);
      @(negedge i_etx_clk);
      // ready, rsp valid, etxd, en, er, emdio_o, emdio_t
      if ({o_req_ready, o_rsp_valid, o_etxd, o_etx_en, o_etx_er, o_emdio_o, o_emdio_t} !== 14'h2001)
         report_mismatch(t.name, 64'h2001, 64'({o_req_ready, o_rsp_valid, o_etxd,
                                                 o_etx_en, o_etx_er, o_emdio_o, o_emdio_t}));
      if (o_reset_vector !== board_pkg::RESET_VEC_ROM)
         report_mismatch(t.name, 64'(board_pkg::RESET_VEC_ROM), 64'(o_reset_vector));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence

   initial begin
      bram_pkg::word_t wdata;
      void'($urandom(32'hfab));
      last_vec     = board_pkg::RESET_VEC_ROM;
      last_phy     = {4'h0, 8'h01, 1'b0};   // idle MAC inputs, MDIO released
      i_rst        <= 1'b1;
      i_req_valid  <= 1'b0;
      i_req_we     <= 1'b0;
      i_req_addr   <= '0;
      i_req_strb   <= '0;
      i_req_wdata  <= '0;
      i_rsp_ready  <= 1'b1;
      i_dip        <= '0;
      {i_tx_data, i_tx_en, i_tx_er, i_mdio_o} <= '0;
      i_mdio_t     <= 1'b1;   // MDIO released
      {i_emdio_i, i_mac_rstn, i_clk_locked} <= '0;
      repeat (RESET_CYCLES) @(posedge i_etx_clk);
      i_rst <= 1'b0;

      for (int n = 0; n < STIM_LEN; n++) begin
         case (STIM[n].op)
            OP_RESET: check_reset_values(STIM[n]);
            OP_WRITE: begin
               wdata = {$urandom, $urandom};
               issue_request(STIM[n], 1'b1, wdata);
               store_word(STIM[n].addr, STIM[n].strb, wdata);
            end
            OP_READ, OP_STALL: run_read(STIM[n]);
            OP_DIP: run_dip(STIM[n]);
            default: run_phy(STIM[n]);
         endcase
         tests_done++;
      end

      $display("tests run: %0d, errors: %0d", tests_done, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   // watchdog, 20 cycles per record plus reset
   initial begin
      #(RUN_CYCLES * CLK_PERIOD);
      $display("run did not finish within %0d cycles, stopped by the watchdog", RUN_CYCLES);
      $display("tests run: %0d, errors: %0d", tests_done, errors + 1);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- design/soc_board_top.sv
// board glue top; boot RAM port and array, reset-vector config and PHY register stage
module soc_board_top (
   input  logic                    i_etx_clk,
   input  logic                    i_rst,
   // boot RAM request
   input  logic                    i_req_valid,
   output logic                    o_req_ready,
   input  logic                    i_req_we,
   input  bram_pkg::byte_addr_t    i_req_addr,
   input  bram_pkg::strb_t         i_req_strb,
   input  bram_pkg::word_t         i_req_wdata,
   // boot RAM read response
   output logic                    o_rsp_valid,
   input  logic                    i_rsp_ready,
   output bram_pkg::word_t         o_rsp_rdata,
   // DIP and reset vector
   input  board_pkg::dip_t         i_dip,
   output board_pkg::reset_vec_t   o_reset_vector,
   // MAC side
   input  board_pkg::mii_nibble_t  i_tx_data,
   input  logic                    i_tx_en,
   input  logic                    i_tx_er,
   input  logic                    i_mdio_o,
   input  logic                    i_mdio_t,
   output logic                    o_mdio_i,
   input  logic                    i_mac_rstn,
   input  logic                    i_clk_locked,
   // PHY pins
   output board_pkg::phy_txd_t     o_etxd,
   output logic                    o_etx_en,
   output logic                    o_etx_er,
   output logic                    o_emdio_o,
   output logic                    o_emdio_t,
   input  logic                    i_emdio_i,
   output logic                    o_erstn
);

   // port to array
   logic                 ram_en;
   bram_pkg::line_idx_t  ram_line;
   bram_pkg::lane_t      ram_lane;
   bram_pkg::line_strb_t ram_we;
   bram_pkg::line_t      ram_wdata;
   bram_pkg::word_t      ram_rdata;

   ////////////////////////////////////////////////////////////////////////////
   // boot RAM

   boot_ram_port boot_ram_port_inst (
      .i_etx_clk   (i_etx_clk),
      .i_rst       (i_rst),
      .i_req_valid (i_req_valid),
      .o_req_ready (o_req_ready),
      .i_req_we    (i_req_we),
      .i_req_addr  (i_req_addr),
      .i_req_strb  (i_req_strb),
      .i_req_wdata (i_req_wdata),
      .o_rsp_valid (o_rsp_valid),
      .i_rsp_ready (i_rsp_ready),
      .o_rsp_rdata (o_rsp_rdata),
      .o_ram_en    (ram_en),
      .o_ram_line  (ram_line),
      .o_ram_lane  (ram_lane),
      .o_ram_we    (ram_we),
      .o_ram_wdata (ram_wdata),
      .i_ram_rdata (ram_rdata)
   );

   boot_ram_array boot_ram_array_inst (
      .i_etx_clk (i_etx_clk),
      .i_en      (ram_en),
      .i_line    (ram_line),
      .i_lane    (ram_lane),
      .i_we      (ram_we),
      .i_wdata   (ram_wdata),
      .o_rdata   (ram_rdata)
   );

   ////////////////////////////////////////////////////////////////////////////
   // board config and Ethernet PHY stage

   board_config board_config_inst (
      .i_etx_clk      (i_etx_clk),
      .i_rst          (i_rst),
      .i_dip          (i_dip),
      .o_reset_vector (o_reset_vector)
   );

   eth_phy_regs eth_phy_regs_inst (
      .i_etx_clk    (i_etx_clk),
      .i_rst        (i_rst),
      .i_tx_data    (i_tx_data),
      .i_tx_en      (i_tx_en),
      .i_tx_er      (i_tx_er),
      .i_mdio_o     (i_mdio_o),
      .i_mdio_t     (i_mdio_t),
      .o_mdio_i     (o_mdio_i),
      .i_mac_rstn   (i_mac_rstn),
      .i_clk_locked (i_clk_locked),
      .o_etxd       (o_etxd),
      .o_etx_en     (o_etx_en),
      .o_etx_er     (o_etx_er),
      .o_emdio_o    (o_emdio_o),
      .o_emdio_t    (o_emdio_t),
      .i_emdio_i    (i_emdio_i),
      .o_erstn      (o_erstn)
   );

endmodule

//--- design/eth_phy_regs.sv
// PHY-side Ethernet register stage for transmit data, MDIO pins and the PHY reset
module eth_phy_regs (
   input  logic                    i_etx_clk,
   input  logic                    i_rst,
   // MAC side
   input  board_pkg::mii_nibble_t  i_tx_data,
   input  logic                    i_tx_en,
   input  logic                    i_tx_er,
   input  logic                    i_mdio_o,
   input  logic                    i_mdio_t,
   output logic                    o_mdio_i,
   input  logic                    i_mac_rstn,
   input  logic                    i_clk_locked,
   // PHY pins
   output board_pkg::phy_txd_t     o_etxd,
   output logic                    o_etx_en,
   output logic                    o_etx_er,
   output logic                    o_emdio_o,
   output logic                    o_emdio_t,
   input  logic                    i_emdio_i,
   output logic                    o_erstn
);

   localparam int PAD_BITS = board_pkg::PHY_DATA_WIDTH - board_pkg::MII_WIDTH;

   ////////////////////////////////////////////////////////////////////////////
   // transmit path

   always_ff @(posedge i_etx_clk) begin
      if (i_rst) begin
         o_etxd   <= '0;
         o_etx_en <= 1'b0;
         o_etx_er <= 1'b0;
      end else begin
         o_etxd   <= {{PAD_BITS{1'b0}}, i_tx_data};   // nibble in the low half
         o_etx_en <= i_tx_en;
         o_etx_er <= i_tx_er;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // MDIO

   always_ff @(posedge i_etx_clk) begin
      if (i_rst) begin
         o_emdio_o <= 1'b0;
         o_emdio_t <= 1'b1;     // released, PHY pulls the line
         o_mdio_i  <= 1'b0;
      end else begin
         o_emdio_o <= i_mdio_o;
         o_emdio_t <= i_mdio_t;
         o_mdio_i  <= i_emdio_i;   // sample toward the MAC
      end
   end

   // hold the PHY in reset until the clocks are locked
   assign o_erstn = i_mac_rstn & i_clk_locked;

endmodule

//--- design/board_config.sv
// DIP switch synchronizer and reset-vector decode for the core boot address
module board_config (
   input  logic                   i_etx_clk,
   input  logic                   i_rst,
   input  board_pkg::dip_t        i_dip,
   output board_pkg::reset_vec_t  o_reset_vector
);

   board_pkg::dip_t       dip_sync [board_pkg::SYNC_STAGES];
   board_pkg::reset_vec_t vec_dec;

   ////////////////////////////////////////////////////////////////////////////
   // synchronizer, switches are asynchronous to the clock

   always_ff @(posedge i_etx_clk) begin
      if (i_rst) begin
         for (int i = 0; i < board_pkg::SYNC_STAGES; i++) begin
            dip_sync[i] <= '0;
         end
      end else begin
         dip_sync[0] <= i_dip;
         for (int i = 1; i < board_pkg::SYNC_STAGES; i++) begin
            dip_sync[i] <= dip_sync[i-1];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // decode, only the low two switches matter

   always_comb begin
      casez (dip_sync[board_pkg::SYNC_STAGES-1][1:0])
         2'b?0:   vec_dec = board_pkg::RESET_VEC_ROM;
         2'b01:   vec_dec = board_pkg::RESET_VEC_DRAM;
         2'b11:   vec_dec = board_pkg::RESET_VEC_KERNEL;
         default: vec_dec = board_pkg::RESET_VEC_ROM;
      endcase
   end

   always_ff @(posedge i_etx_clk) begin
      if (i_rst) begin
         o_reset_vector <= board_pkg::RESET_VEC_ROM;   // boot from ROM
      end else begin
         o_reset_vector <= vec_dec;
      end
   end

endmodule

//--- design/boot_ram_port.sv
// boot RAM word port; request/response handshake and lane steering toward the line array
module boot_ram_port (
   input  logic                  i_etx_clk,
   input  logic                  i_rst,
   // request channel
   input  logic                  i_req_valid,
   output logic                  o_req_ready,
   input  logic                  i_req_we,
   input  bram_pkg::byte_addr_t  i_req_addr,
   input  bram_pkg::strb_t       i_req_strb,
   input  bram_pkg::word_t       i_req_wdata,
   // read response channel
   output logic                  o_rsp_valid,
   input  logic                  i_rsp_ready,
   output bram_pkg::word_t       o_rsp_rdata,
   // array side
   output logic                  o_ram_en,
   output bram_pkg::line_idx_t   o_ram_line,
   output bram_pkg::lane_t       o_ram_lane,
   output bram_pkg::line_strb_t  o_ram_we,
   output bram_pkg::line_t       o_ram_wdata,
   input  bram_pkg::word_t       i_ram_rdata
);

   logic                 req_fire;
   logic                 rsp_fire;
   logic                 rsp_held;    // response already stalled a cycle
   bram_pkg::word_t      rsp_q;
   bram_pkg::line_strb_t lane_strb;

   assign rsp_fire = o_rsp_valid & i_rsp_ready;

   // one read in flight, ready again as soon as the response leaves
   assign o_req_ready = ~o_rsp_valid | i_rsp_ready;
   assign req_fire    = i_req_valid & o_req_ready;

   ////////////////////////////////////////////////////////////////////////////
   // address split and lane steering

   // byte offset within the word is ignored, strobes carry it
   assign o_ram_line = i_req_addr[bram_pkg::BRAM_SIZE-1 -: bram_pkg::BLK_BITS];
   assign o_ram_lane = i_req_addr[bram_pkg::OFFSET_BITS +: bram_pkg::LSB_BITS];

   assign lane_strb = bram_pkg::line_strb_t'(i_req_strb)
                      << (o_ram_lane * (bram_pkg::WORD_WIDTH / 8));

   assign o_ram_en    = req_fire;
   assign o_ram_we    = (req_fire & i_req_we) ? lane_strb : '0;
   assign o_ram_wdata = {(bram_pkg::BRAM_WIDTH / bram_pkg::WORD_WIDTH){i_req_wdata}};

   ////////////////////////////////////////////////////////////////////////////
   // read response

   always_ff @(posedge i_etx_clk) begin
      if (i_rst) begin
         o_rsp_valid <= 1'b0;
         rsp_held    <= 1'b0;
      end else begin
         if (req_fire && !i_req_we) begin
            o_rsp_valid <= 1'b1;   // data is out of the array next cycle
         end else if (rsp_fire) begin
            o_rsp_valid <= 1'b0;
         end
         rsp_held <= o_rsp_valid & ~i_rsp_ready;
      end
   end

   // keep the word from the first response cycle while stalled
   always_ff @(posedge i_etx_clk) begin
      if (o_rsp_valid && !rsp_held) begin
         rsp_q <= i_ram_rdata;
      end
   end

   assign o_rsp_rdata = rsp_held ? rsp_q : i_ram_rdata;

endmodule

//--- design/boot_ram_array.sv
// line-wide boot RAM storage with byte write enables and a registered word-lane read
module boot_ram_array (
   input  logic                 i_etx_clk,
   input  logic                 i_en,
   input  bram_pkg::line_idx_t  i_line,
   input  bram_pkg::lane_t      i_lane,
   input  bram_pkg::line_strb_t i_we,
   input  bram_pkg::line_t      i_wdata,
   output bram_pkg::word_t      o_rdata
);

   bram_pkg::line_t     mem [bram_pkg::BRAM_LINES];

   bram_pkg::line_idx_t line_q;   // address of the last access
   bram_pkg::lane_t     lane_q;
   bram_pkg::line_t     rd_line;

   ////////////////////////////////////////////////////////////////////////////
   // write and address capture

   // contents start undefined, no reset on the array
   always_ff @(posedge i_etx_clk) begin
      if (i_en) begin
         line_q <= i_line;
         lane_q <= i_lane;
         for (int i = 0; i < bram_pkg::BRAM_WIDTH / 8; i++) begin
            if (i_we[i]) begin
               mem[i_line][i*8 +: 8] <= i_wdata[i*8 +: 8];
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read

   // line out of the registered index, then pick the lane
   assign rd_line = mem[line_q];
   assign o_rdata = rd_line[lane_q * bram_pkg::WORD_WIDTH +: bram_pkg::WORD_WIDTH];

endmodule

//--- design/board_pkg.sv
// board-level constants and types for the DIP decode and the PHY-side Ethernet stage
package board_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // DIP switches and reset vector

   localparam int DIP_WIDTH   = 4;
   localparam int SYNC_STAGES = 2;   // synchronizer depth

   typedef logic [DIP_WIDTH-1:0] dip_t;
   typedef logic [31:0]          reset_vec_t;

   // boot targets picked by dip[1:0]
   localparam reset_vec_t RESET_VEC_ROM    = 32'h4000_0000;  // dip[0] low
   localparam reset_vec_t RESET_VEC_DRAM   = 32'h8000_0000;  // 01
   localparam reset_vec_t RESET_VEC_KERNEL = 32'h8020_0000;  // 11

   ////////////////////////////////////////////////////////////////////////////
   // Ethernet transmit widths

   localparam int MII_WIDTH      = 4;   // MAC nibble
   localparam int PHY_DATA_WIDTH = 8;   // GMII-style PHY byte

   typedef logic [MII_WIDTH-1:0]      mii_nibble_t;
   typedef logic [PHY_DATA_WIDTH-1:0] phy_txd_t;

endpackage

//--- design/bram_pkg.sv
// boot RAM geometry and data types, shared by the word port and the line array
package bram_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // geometry

   localparam int BRAM_SIZE  = 12;    // log2 of bytes, 4 KB
   localparam int BRAM_WIDTH = 128;   // line width
   localparam int WORD_WIDTH = 64;    // port word width

   localparam int BRAM_LINES = (2 ** BRAM_SIZE) / (BRAM_WIDTH / 8);

   // address split, byte-in-word / word-in-line / line index
   // word width is fixed at 64, so the byte offset is a constant
   localparam int OFFSET_BITS = 3;
   localparam int LSB_BITS    = $clog2(BRAM_WIDTH / WORD_WIDTH);
   localparam int BLK_BITS    = BRAM_SIZE - LSB_BITS - OFFSET_BITS;

   ////////////////////////////////////////////////////////////////////////////
   // types

   typedef logic [BRAM_SIZE-1:0]      byte_addr_t;
   typedef logic [BLK_BITS-1:0]       line_idx_t;
   typedef logic [LSB_BITS-1:0]       lane_t;     // which word of the line

   typedef logic [WORD_WIDTH-1:0]     word_t;
   typedef logic [WORD_WIDTH/8-1:0]   strb_t;
   typedef logic [BRAM_WIDTH-1:0]     line_t;
   typedef logic [BRAM_WIDTH/8-1:0]   line_strb_t; // one enable per line byte

endpackage
